// File: design/lsu_pkg.sv
// Load/store unit shared types

package lsu_pkg;

  parameter int unsigned DataWidth = 32;
  parameter int unsigned AddrWidth = 32;

  // access size as encoded by the decoder
  typedef enum logic [1:0] {
    LSU_WORD     = 2'b00,
    LSU_HALF     = 2'b01,
    LSU_BYTE     = 2'b10,
    LSU_BYTE_ALT = 2'b11   // byte, upper encoding
  } lsu_type_e;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

  // request payload from the execute stage, held until done
  typedef struct packed {
    logic                 we;
    lsu_type_e            lsu_type;
    logic                 sign_ext;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } lsu_req_t;

  // one word-aligned request on the data bus
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [3:0]           be;
    logic [DataWidth-1:0] wdata;
  } data_req_t;

  // control of the access in flight
  typedef struct packed {
    logic [1:0] offset;
    lsu_type_e  lsu_type;
    logic       sign_ext;
    logic       we;
  } lsu_ctrl_t;

endpackage

// File: design/lsu_req_align.sv
// Bus request alignment

`timescale 1ns/1ps

module lsu_req_align import lsu_pkg::*; (
  input  lsu_req_t  req_i,
  input  logic      handle_misaligned_i,  // high for the second half of a split access
  output data_req_t bus_o
);

  logic [1:0]           offset;
  logic [3:0]           be;
  logic [DataWidth-1:0] wdata_rot;

  assign offset = req_i.addr[1:0];

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    be = 4'b1111;
    unique case (req_i.lsu_type)
      LSU_WORD: begin
        if (!handle_misaligned_i) begin
          be = 4'b1111 << offset;   // upper lanes of the first word
        end else begin
          be = 4'b1111 >> (3'd4 - {1'b0, offset});   // lower lanes of the next word
        end
      end
      LSU_HALF: begin
        if (!handle_misaligned_i) begin
          be = (offset == 2'b11) ? 4'b1000 : (4'b0011 << offset);
        end else begin
          be = 4'b0001;  // only offset 3 splits
        end
      end
      LSU_BYTE,
      LSU_BYTE_ALT: be = 4'b0001 << offset;
      default:      be = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // store data lanes
  //////////////////////////////////////////////////////////////////////

  // rotate left by the byte offset so each byte lands on its lane
  always_comb begin
    unique case (offset)
      2'b00:   wdata_rot = req_i.wdata;
      2'b01:   wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      2'b11:   wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
      default: wdata_rot = req_i.wdata;
    endcase
  end

  assign bus_o.addr  = {req_i.addr[AddrWidth-1:2], 2'b00};  // always word aligned
  assign bus_o.we    = req_i.we;
  assign bus_o.be    = be;
  assign bus_o.wdata = wdata_rot;

endmodule

// File: design/lsu_rdata_align.sv
// Load data realignment

`timescale 1ns/1ps

module lsu_rdata_align import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rdata_update_i,  // first half of a split load returns
  input  lsu_ctrl_t            ctrl_i,
  input  logic [DataWidth-1:0] data_rdata_i,
  output logic [DataWidth-1:0] lsu_rdata_o
);

  logic [23:0]          rdata_q;   // bytes 3..1 of the first word
  logic [DataWidth-1:0] rdata_w;
  logic [15:0]          rdata_h;
  logic [7:0]           rdata_b;

  // only the upper lanes of the first word ever reach the result
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rdata_update_i) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lane selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl_i.offset)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0], rdata_q};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[23:8]};
      2'b11:   rdata_w = {data_rdata_i[23:0], rdata_q[23:16]};
      default: rdata_w = data_rdata_i;
    endcase
  end

  // halfword at offset 3 spans two words
  always_comb begin
    unique case (ctrl_i.offset)
      2'b00:   rdata_h = data_rdata_i[15:0];
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      2'b11:   rdata_h = {data_rdata_i[7:0], rdata_q[23:16]};
      default: rdata_h = data_rdata_i[15:0];
    endcase
  end

  always_comb begin
    unique case (ctrl_i.offset)
      2'b00:   rdata_b = data_rdata_i[7:0];
      2'b01:   rdata_b = data_rdata_i[15:8];
      2'b10:   rdata_b = data_rdata_i[23:16];
      2'b11:   rdata_b = data_rdata_i[31:24];
      default: rdata_b = data_rdata_i[7:0];
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // extension by size
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl_i.lsu_type)
      LSU_WORD:     lsu_rdata_o = rdata_w;
      LSU_HALF:     lsu_rdata_o = {{16{ctrl_i.sign_ext & rdata_h[15]}}, rdata_h};
      LSU_BYTE,
      LSU_BYTE_ALT: lsu_rdata_o = {{24{ctrl_i.sign_ext & rdata_b[7]}}, rdata_b};
      default:      lsu_rdata_o = rdata_w;
    endcase
  end

endmodule

// File: design/lsu_ctrl_fsm.sv
// Load/store request FSM

`timescale 1ns/1ps

module lsu_ctrl_fsm import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lsu_req_i,
  input  lsu_req_t             lsu_req_data_i,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  input  logic                 data_pmp_err_i,
  output logic                 data_req_o,
  output logic                 addr_incr_req_o,      // core presents addr_last_o + 4
  output logic                 handle_misaligned_o,
  output logic                 rdata_update_o,
  output lsu_ctrl_t            ctrl_q_o,
  output logic [AddrWidth-1:0] addr_last_o,          // for mtval and the second half
  output logic                 lsu_req_done_o,
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic                 busy_o
);

  ls_fsm_e              ls_fsm_cs, ls_fsm_ns;
  lsu_ctrl_t            ctrl_q, ctrl_d;
  logic [AddrWidth-1:0] addr_last_q, addr_last_d;
  logic                 handle_misaligned_q, handle_misaligned_d;
  logic                 pmp_err_q, pmp_err_d;
  logic                 lsu_err_q, lsu_err_d;   // error seen on the first half
  logic                 addr_update, ctrl_update;
  logic                 split_misaligned;
  logic                 lsu_go;
  logic                 data_or_pmp_err;

  assign ctrl_d = '{offset:   lsu_req_data_i.addr[1:0],
                    lsu_type: lsu_req_data_i.lsu_type,
                    sign_ext: lsu_req_data_i.sign_ext,
                    we:       lsu_req_data_i.we};

  // words off a word boundary and halfwords at offset 3 need two accesses
  assign split_misaligned =
      ((ctrl_d.lsu_type == LSU_WORD) && (ctrl_d.offset != 2'b00)) ||
      ((ctrl_d.lsu_type == LSU_HALF) && (ctrl_d.offset == 2'b11));

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ls_fsm_ns           = ls_fsm_cs;
    data_req_o          = 1'b0;
    addr_incr_req_o     = 1'b0;
    handle_misaligned_d = handle_misaligned_q;
    pmp_err_d           = pmp_err_q;
    lsu_err_d           = lsu_err_q;
    addr_update         = 1'b0;
    ctrl_update         = 1'b0;
    rdata_update_o      = 1'b0;
    lsu_go              = 1'b0;

    unique case (ls_fsm_cs)
      IDLE: begin
        pmp_err_d = 1'b0;
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          pmp_err_d  = data_pmp_err_i;  // sampled in the address phase
          lsu_err_d  = 1'b0;
          lsu_go     = 1'b1;
          if (data_gnt_i) begin
            ctrl_update         = 1'b1;
            addr_update         = 1'b1;
            handle_misaligned_d = split_misaligned;
            ls_fsm_ns           = split_misaligned ? WAIT_RVALID_MIS : IDLE;
          end else begin
            ls_fsm_ns           = split_misaligned ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        // a PMP-blocked request never sees a grant
        if (data_gnt_i || pmp_err_q) begin
          addr_update         = 1'b1;
          ctrl_update         = 1'b1;
          handle_misaligned_d = 1'b1;
          ls_fsm_ns           = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;   // second half goes out now
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i || pmp_err_q) begin
          pmp_err_d           = data_pmp_err_i;
          lsu_err_d           = data_err_i | pmp_err_q;
          rdata_update_o      = ~ctrl_q.we;
          ls_fsm_ns           = data_gnt_i ? IDLE : WAIT_GNT;
          addr_update         = data_gnt_i & ~(data_err_i | pmp_err_q);
          handle_misaligned_d = ~data_gnt_i;
        end else if (data_gnt_i) begin
          ls_fsm_ns           = WAIT_RVALID_MIS_GNTS_DONE;  // two requests outstanding
          handle_misaligned_d = 1'b0;
        end
      end

      WAIT_GNT: begin
        addr_incr_req_o = handle_misaligned_q;
        data_req_o      = 1'b1;
        if (data_gnt_i || pmp_err_q) begin
          ctrl_update         = 1'b1;
          addr_update         = ~lsu_err_q;  // keep the failing address
          handle_misaligned_d = 1'b0;
          ls_fsm_ns           = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;   // keeps the second address valid for addr_last
        if (data_rvalid_i) begin
          pmp_err_d      = data_pmp_err_i;
          lsu_err_d      = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~ctrl_q.we;
          ls_fsm_ns      = IDLE;
        end
      end

      default: ls_fsm_ns = IDLE;
    endcase
  end

  // first half or aligned access keeps the byte address
  assign addr_last_d = addr_incr_req_o ? {lsu_req_data_i.addr[AddrWidth-1:2], 2'b00}
                                       : lsu_req_data_i.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs           <= IDLE;
      handle_misaligned_q <= 1'b0;
      pmp_err_q           <= 1'b0;
      lsu_err_q           <= 1'b0;
      ctrl_q              <= '0;
      addr_last_q         <= '0;
    end else begin
      ls_fsm_cs           <= ls_fsm_ns;
      handle_misaligned_q <= handle_misaligned_d;
      pmp_err_q           <= pmp_err_d;
      lsu_err_q           <= lsu_err_d;
      if (ctrl_update) ctrl_q <= ctrl_d;
      if (addr_update) addr_last_q <= addr_last_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign data_or_pmp_err     = lsu_err_q | data_err_i | pmp_err_q;

  assign lsu_req_done_o      = (lsu_go | (ls_fsm_cs != IDLE)) & (ls_fsm_ns == IDLE);
  assign lsu_resp_valid_o    = (data_rvalid_i | pmp_err_q) & (ls_fsm_cs == IDLE);
  assign lsu_rdata_valid_o   = (ls_fsm_cs == IDLE) & data_rvalid_i & ~data_or_pmp_err &
                               ~ctrl_q.we;
  assign load_err_o          = data_or_pmp_err & ~ctrl_q.we & lsu_resp_valid_o;
  assign store_err_o         = data_or_pmp_err &  ctrl_q.we & lsu_resp_valid_o;

  assign handle_misaligned_o = handle_misaligned_q;
  assign ctrl_q_o            = ctrl_q;
  assign addr_last_o         = addr_last_q;
  assign busy_o              = (ls_fsm_cs != IDLE);

endmodule

// File: design/load_store_unit.sv
// Data-side load/store unit

`timescale 1ns/1ps

module load_store_unit import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // execute stage
  input  logic                 lsu_req_i,
  input  lsu_req_t             lsu_req_i_data,
  output logic [DataWidth-1:0] lsu_rdata_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 addr_incr_req_o,
  output logic [AddrWidth-1:0] addr_last_o,
  output logic                 lsu_req_done_o,
  output logic                 lsu_resp_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic                 busy_o,

  // data bus
  output logic                 data_req_o,
  output data_req_t            data_bus_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic [DataWidth-1:0] data_rdata_i,
  input  logic                 data_err_i,
  input  logic                 data_pmp_err_i
);

  logic      handle_misaligned;
  logic      rdata_update;
  lsu_ctrl_t ctrl_q;

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .lsu_req_i           (lsu_req_i),
    .lsu_req_data_i      (lsu_req_i_data),
    .data_gnt_i          (data_gnt_i),
    .data_rvalid_i       (data_rvalid_i),
    .data_err_i          (data_err_i),
    .data_pmp_err_i      (data_pmp_err_i),
    .data_req_o          (data_req_o),
    .addr_incr_req_o     (addr_incr_req_o),
    .handle_misaligned_o (handle_misaligned),
    .rdata_update_o      (rdata_update),
    .ctrl_q_o            (ctrl_q),
    .addr_last_o         (addr_last_o),
    .lsu_req_done_o      (lsu_req_done_o),
    .lsu_resp_valid_o    (lsu_resp_valid_o),
    .lsu_rdata_valid_o   (lsu_rdata_valid_o),
    .load_err_o          (load_err_o),
    .store_err_o         (store_err_o),
    .busy_o              (busy_o)
  );

  lsu_req_align u_req_align (
    .req_i               (lsu_req_i_data),
    .handle_misaligned_i (handle_misaligned),
    .bus_o               (data_bus_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rdata_update_i (rdata_update),
    .ctrl_i         (ctrl_q),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

// File: tb/lsu_clk_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps

module lsu_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: tb/lsu_assert.sv
// Load/store unit bus checks

`timescale 1ns/1ps

module lsu_assert import lsu_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      data_req_o,
  input logic      data_gnt_i,
  input data_req_t data_bus_o,
  input lsu_req_t  lsu_req_i_data,
  input logic      handle_misaligned,
  input logic      load_err_o,
  input logic      store_err_o,
  input logic      lsu_resp_valid_o,
  input logic      busy_o
);

  int unsigned fail_cnt = 0;

  // byte enable table by size, offset and half
  function automatic logic [3:0] expected_be(lsu_type_e t, logic [1:0] off, logic second);
    logic [3:0] be;
    if (t == LSU_WORD) begin
      be = second ? ((off == 2'd1) ? 4'b0001 : (off == 2'd2) ? 4'b0011 : 4'b0111)
                  : ((off == 2'd0) ? 4'b1111 : (off == 2'd1) ? 4'b1110 :
                     (off == 2'd2) ? 4'b1100 : 4'b1000);
    end else if (t == LSU_HALF) begin
      be = second ? 4'b0001
                  : ((off == 2'd0) ? 4'b0011 : (off == 2'd1) ? 4'b0110 :
                     (off == 2'd2) ? 4'b1100 : 4'b1000);
    end else begin
      be = (off == 2'd0) ? 4'b0001 : (off == 2'd1) ? 4'b0010 :
           (off == 2'd2) ? 4'b0100 : 4'b1000;   // one-hot byte lane
    end
    return be;
  endfunction

  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> data_bus_o.addr[1:0] == 2'b00)
    else begin $error("bus address not word aligned"); fail_cnt++; end

  a_byte_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && data_gnt_i) |-> data_bus_o.be == expected_be(lsu_req_i_data.lsu_type,
                                   lsu_req_i_data.addr[1:0], handle_misaligned))
    else begin $error("wrong byte enables on granted request"); fail_cnt++; end

  a_err_with_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (load_err_o || store_err_o) |-> lsu_resp_valid_o)
    else begin $error("error output without response valid"); fail_cnt++; end

  a_reset_idle: assert property (@(posedge clk_i) $rose(rst_ni) |-> !busy_o && !data_req_o)
    else begin $error("unit not idle after reset"); fail_cnt++; end

endmodule

bind load_store_unit lsu_assert u_lsu_assert (.*);

// File: tb/tb_load_store_unit.sv
// Load/store unit testbench

`timescale 1ns/1ps

module tb_load_store_unit import lsu_pkg::*; ();

  logic clk_i, rst_ni;
  logic lsu_req_i, data_gnt_i, data_rvalid_i, data_err_i, data_pmp_err_i;
  logic lsu_rdata_valid_o, addr_incr_req_o, lsu_req_done_o, lsu_resp_valid_o;
  logic load_err_o, store_err_o, busy_o, data_req_o;
  logic [31:0] lsu_rdata_o, addr_last_o, data_rdata_i;
  lsu_req_t  req_q, req_w;
  data_req_t data_bus_o;

  logic [31:0] bus_mem [64];   // memory seen by the bus
  logic [31:0] ref_mem [64];   // expected contents
  int          err_cnt, done_cnt, cyc, last_due, gnt_wait;
  logic        inject_err, pmp_block;
  logic [31:0] gnt_addrs[$], rdata_q[$], waddr[8];
  logic        gnt_incr[$], err_q[$];
  int          due_q[$];
  logic [31:0] got_rdata;
  logic        got_rvalid, got_lerr, got_serr;

  lsu_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  load_store_unit load_store_unit_inst (.lsu_req_i_data(req_w), .*);

  // core side mux for the second half address
  always_comb begin
    req_w = req_q;
    if (addr_incr_req_o) req_w.addr = addr_last_o + 32'd4;
  end

  //////////////////////////////////////////////////////////////////////
  // bus model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int due;
    cyc++;
    if (rst_ni && data_req_o && data_gnt_i) begin
      for (int k = 0; k < 4; k++) begin
        if (data_bus_o.we && !inject_err && data_bus_o.be[k])
          bus_mem[data_bus_o.addr[7:2]][8*k +: 8] = data_bus_o.wdata[8*k +: 8];
      end
      due = cyc + $urandom_range(0, 2);
      if (due <= last_due) due = last_due + 1;   // keep responses in order
      last_due = due;
      due_q.push_back(due);
      rdata_q.push_back(bus_mem[data_bus_o.addr[7:2]]);
      err_q.push_back(inject_err);
      gnt_addrs.push_back(data_bus_o.addr);
      gnt_incr.push_back(addr_incr_req_o);
      gnt_wait = $urandom_range(0, 2);
    end else if (data_req_o && gnt_wait != 0) begin
      gnt_wait--;
    end
    if (rst_ni && lsu_req_done_o) done_cnt++;
    data_gnt_i    <= (gnt_wait == 0) && !pmp_block;
    data_rvalid_i <= 1'b0;
    data_err_i    <= 1'b0;
    if (due_q.size() != 0 && due_q[0] <= cyc) begin
      void'(due_q.pop_front());
      data_rvalid_i <= 1'b1;
      data_rdata_i  <= rdata_q.pop_front();
      data_err_i    <= err_q.pop_front();
    end
  end

  function automatic int size_of(lsu_type_e t);
    return (t == LSU_WORD) ? 4 : (t == LSU_HALF) ? 2 : 1;
  endfunction

  function automatic logic [31:0] expected_load(logic [31:0] a, lsu_type_e t, logic sx);
    logic [31:0] v;
    logic [7:0]  b;
    v = '0;
    for (int k = 0; k < size_of(t); k++) begin
      b = ref_mem[(a + k) >> 2][8*((a + k) & 3) +: 8];
      v[8*k +: 8] = b;
    end
    if (sx && t == LSU_HALF) v[31:16] = {16{v[15]}};
    if (sx && t != LSU_HALF && t != LSU_WORD) v[31:8] = {24{v[7]}};
    return v;
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic fail_timeout(string what);
    $display("timeout at %0t: %s", $time, what);
    $display("test failed");
    $finish;
  endtask

  task automatic run_access(logic we, lsu_type_e t, logic sx, logic [31:0] a,
                            logic [31:0] wdata, logic pmp);
    int n;
    gnt_addrs.delete();
    gnt_incr.delete();
    done_cnt = 0;
    if (pmp) begin
      @(posedge clk_i);
      pmp_block <= 1'b1;   // hold off grants for the blocked half
    end
    @(posedge clk_i);
    req_q          <= '{we: we, lsu_type: t, sign_ext: sx, addr: a, wdata: wdata};
    lsu_req_i      <= 1'b1;
    data_pmp_err_i <= pmp;
    n = 0;
    do begin
      @(posedge clk_i);
      if (n == 1) begin
        data_pmp_err_i <= 1'b0;
        pmp_block      <= 1'b0;
      end
      n++;
      if (n > 50) fail_timeout("request never completed");
    end while (!lsu_req_done_o);
    lsu_req_i <= 1'b0;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > 50) fail_timeout("no response for the access");
    end while (!lsu_resp_valid_o);
    got_rdata  = lsu_rdata_o;
    got_rvalid = lsu_rdata_valid_o;
    got_lerr   = load_err_o;
    got_serr   = store_err_o;
    check_val("lsu_req_done_o count", 1, done_cnt);
    if ((t == LSU_WORD && a[1:0] != 0) || (t == LSU_HALF && a[1:0] == 3)) begin
      if (!pmp) begin
        check_val("granted requests", 2, gnt_addrs.size());
        check_val("first word address", {a[31:2], 2'b00}, gnt_addrs[0]);
        check_val("second word address", gnt_addrs[0] + 4, gnt_addrs[1]);
        check_val("addr_incr_req_o", 1, gnt_incr[1]);
      end
    end
  endtask

  task automatic store_access(logic [31:0] a, lsu_type_e t, logic [31:0] wdata);
    run_access(1'b1, t, 1'b0, a, wdata, 1'b0);
    for (int k = 0; k < size_of(t); k++) ref_mem[(a + k) >> 2][8*((a + k) & 3) +: 8] =
                                           wdata[8*k +: 8];
    check_val("store_err_o", 0, got_serr);
  endtask

  task automatic load_access(logic [31:0] a, lsu_type_e t, logic sx);
    run_access(1'b0, t, sx, a, 32'h0, 1'b0);
    check_val("lsu_rdata_valid_o", 1, got_rvalid);
    check_val("lsu_rdata_o", expected_load(a, t, sx), got_rdata);
    check_val("load_err_o", 0, got_lerr);
  endtask

  initial begin
    int n;
    void'($urandom(32'h03e4061c));
    lsu_req_i      = 1'b0;
    req_q          = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    data_err_i     = 1'b0;
    data_pmp_err_i = 1'b0;
    inject_err     = 1'b0;
    pmp_block      = 1'b0;
    err_cnt        = 0;
    cyc            = 0;
    last_due       = 0;
    gnt_wait       = 0;
    for (int i = 0; i < 64; i++) begin
      bus_mem[i] = 32'h8f17_c3a5 ^ (i * 32'h0101_0101);   // differs for every word
      ref_mem[i] = bus_mem[i];
    end
    n = 0;
    while (rst_ni !== 1'b1) begin
      @(posedge clk_i);
      n++;
      if (n > 100) fail_timeout("reset never released");
    end
    repeat (2) @(posedge clk_i);
    // aligned round trip
    for (int i = 0; i < 8; i++) begin
      waddr[i] = $urandom_range(0, 59) << 2;
      store_access(waddr[i], LSU_WORD, $urandom());
    end
    for (int i = 0; i < 8; i++) load_access(waddr[i], LSU_WORD, 1'b0);
    // byte and halfword lanes
    for (int off = 0; off < 4; off++) begin
      for (int sx = 0; sx < 2; sx++) begin
        load_access(64 + off, LSU_BYTE, 1'(sx));
        load_access(68 + off, LSU_HALF, 1'(sx));
      end
    end
    // split accesses
    for (int off = 1; off < 4; off++) begin
      store_access(128 + off, LSU_WORD, $urandom());
      load_access(128 + off, LSU_WORD, 1'b0);
      load_access(160 + off, LSU_WORD, 1'b0);
    end
    store_access(195, LSU_HALF, $urandom());
    load_access(195, LSU_HALF, 1'b1);
    // bus errors
    inject_err = 1'b1;
    run_access(1'b0, LSU_WORD, 1'b0, 200, 32'h0, 1'b0);
    check_val("load_err_o", 1, got_lerr);
    check_val("lsu_rdata_valid_o", 0, got_rvalid);
    run_access(1'b1, LSU_WORD, 1'b0, 204, 32'h1234_5678, 1'b0);
    check_val("store_err_o", 1, got_serr);
    inject_err = 1'b0;
    // PMP error on the first half
    run_access(1'b0, LSU_WORD, 1'b0, 210, 32'h0, 1'b1);
    check_val("addr_last_o", 210, addr_last_o);
    check_val("load_err_o", 1, got_lerr);
    check_val("lsu_rdata_valid_o", 0, got_rvalid);
    repeat (5) @(posedge clk_i);
    n = load_store_unit_inst.u_lsu_assert.fail_cnt;
    $display("errors: %0d value, %0d assertion", err_cnt, n);
    if (err_cnt == 0 && n == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: list.f
design/lsu_pkg.sv
design/lsu_req_align.sv
design/lsu_rdata_align.sv
design/lsu_ctrl_fsm.sv
design/load_store_unit.sv
tb/lsu_clk_gen.sv
tb/lsu_assert.sv
tb/tb_load_store_unit.sv
